/* mips_macros.svh */
`ifndef MIPS_MACROS_SVH
`define MIPS_MACROS_SVH

// architectural register indices used by the core and its checkers
// register zero is hardwired to zero and is never written
`define REG_ZERO 5'd0

// v0 carries the syscall code and a0 the syscall argument
`define REG_V0 5'd2
`define REG_A0 5'd4

// stack pointer, preset at reset below the top of the stack
`define REG_SP 5'd29

// return address, the implicit destination of jal
`define REG_RA 5'd31

// first instruction address after reset, the usual text segment start
`define RESET_PC 32'h0040_0000

// highest word of the user stack
// sp comes out of reset one word below this address
`define STACK_TOP 32'h7fff_fffc

`endif

/* mips_pkg.sv */
package mips_pkg;

	// primary opcode field, only the subset that the core executes
	typedef enum logic [5:0] {
		OP_RTYPE = 6'h00,
		OP_JAL   = 6'h03,
		OP_ADDIU = 6'h09,
		OP_ORI   = 6'h0d,
		OP_LUI   = 6'h0f
	} opcode_t;

	// function field of the R-type encoding
	typedef enum logic [5:0] {
		F_SYSCALL = 6'h0c,
		F_ADDU    = 6'h21,
		F_SUBU    = 6'h23,
		F_AND     = 6'h24,
		F_OR      = 6'h25,
		F_SLT     = 6'h2a
	} funct_t;

	// operations the ALU knows about
	// pass_a forwards operand a unchanged, which is how the jal link value gets through
	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_SLT,
		ALU_LUI,
		ALU_PASS_A
	} alu_op_t;

	// R-type view of an instruction word
	typedef struct packed {
		opcode_t    opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		funct_t     funct;
	} r_fields_t;

	// I-type view of the same word
	// the jal target is the low 26 bits, i.e. rs, rt and imm16 taken together
	typedef struct packed {
		opcode_t     opcode;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [15:0] imm16;
	} i_fields_t;

	// one instruction word, decoded either way depending on the opcode
	typedef union packed {
		r_fields_t r_fields;
		i_fields_t i_fields;
	} instr_t;

endpackage

/* regfile_if.sv */
`timescale 1ns/1ps

// link between the decoder and the register file
// wr_data is not driven by either side, the top level feeds it from the ALU result
interface regfile_if;

	// source and destination register indices
	logic [4:0] rs;
	logic [4:0] rt;
	logic [4:0] wr_addr;

	// per-instruction control, already qualified by instr_valid
	logic reg_write;
	logic jal;
	logic syscall;

	// value to write back and the link address for jal
	logic [31:0] wr_data;
	logic [31:0] pc_plus_4;

	// combinational read data after the syscall and jal muxing
	logic [31:0] rd1;
	logic [31:0] rd2;

	// decoder side drives addresses and control, gets read data back
	modport decoder (
		output rs, rt, wr_addr, reg_write, jal, syscall, pc_plus_4,
		input  rd1, rd2
	);

	// register file side sees the opposite directions
	modport regfile (
		input  rs, rt, wr_addr, reg_write, jal, syscall, pc_plus_4, wr_data,
		output rd1, rd2
	);

endinterface

/* alu.sv */
`timescale 1ns/1ps

// combinational ALU for the integer subset
// add and subtract wrap silently, the unsigned MIPS forms never trap
module alu
	import mips_pkg::*;
(
	input  alu_op_t      op,
	input  logic [31:0]  a,
	input  logic [31:0]  b,
	output logic [31:0]  result
);

	// signed compare for slt, kept apart so the case below stays readable
	logic less_than;

	assign less_than = $signed(a) < $signed(b);

	always_comb begin
		case (op)
			ALU_ADD: begin
				result = a + b;
			end
			ALU_SUB: begin
				result = a - b;
			end
			ALU_AND: begin
				result = a & b;
			end
			ALU_OR: begin
				result = a | b;
			end
			// slt yields exactly one or zero
			ALU_SLT: begin
				result = {31'd0, less_than};
			end
			// lui takes the zero-extended immediate and moves it to the top half
			ALU_LUI: begin
				result = {b[15:0], 16'd0};
			end
			// jal link value arrives on a from the register file mux
			ALU_PASS_A: begin
				result = a;
			end
			default: begin
				result = 32'd0;
			end
		endcase
	end

endmodule

/* register_file.sv */
`timescale 1ns/1ps
`include "mips_macros.svh"

// 32 x 32 register file with the syscall and jal read steering
// writes happen on the accepting clock edge, the report comes one cycle later
module register_file (
	input  logic              clk,
	input  logic              rst_n,
	regfile_if.regfile        rf,
	output logic              wb_valid,
	output logic [4:0]        wb_addr,
	output logic [31:0]       wb_data,
	output logic              syscall_valid,
	output logic [31:0]       syscall_code,
	output logic [31:0]       syscall_arg
);

	logic [31:0] regs [32];

	// jal always links into ra, no matter what the decoder put on wr_addr
	logic [4:0] dest;

	// final write enable, register zero is filtered out here
	logic wr_en;

	assign dest  = rf.jal ? `REG_RA : rf.wr_addr;
	assign wr_en = rf.reg_write && (dest != `REG_ZERO);

	// read muxing
	// syscall needs v0 and a0 regardless of rs and rt
	// jal feeds the link address through port 1 so the ALU can pass it on
	always_comb begin
		if (rf.syscall) begin
			rf.rd1 = regs[`REG_V0];
			rf.rd2 = regs[`REG_A0];
		end else if (rf.jal) begin
			rf.rd1 = rf.pc_plus_4;
			rf.rd2 = 32'd0;
		end else begin
			rf.rd1 = regs[rf.rs];
			rf.rd2 = regs[rf.rt];
		end
	end

	// register array
	// everything starts at zero except sp, which points just below the stack top
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int k = 0; k < 32; k++) begin
				regs[k] <= 32'd0;
			end
			regs[`REG_SP] <= `STACK_TOP - 32'd4;
		end else if (wr_en) begin
			regs[dest] <= rf.wr_data;
		end
	end

	// report strobes, one cycle after the instruction was taken
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wb_valid      <= 1'b0;
			syscall_valid <= 1'b0;
		end else begin
			wb_valid      <= wr_en;
			syscall_valid <= rf.syscall;
		end
	end

	// report payload only moves when its strobe is about to fire
	always_ff @(posedge clk) begin
		if (wr_en) begin
			wb_addr <= dest;
			wb_data <= rf.wr_data;
		end
		// rd1 and rd2 hold v0 and a0 during a syscall, sampled before any later write
		if (rf.syscall) begin
			syscall_code <= rf.rd1;
			syscall_arg  <= rf.rd2;
		end
	end

endmodule

/* decode_stage.sv */
`timescale 1ns/1ps
`include "mips_macros.svh"

// instruction decode and program counter
// control is purely combinational from the strobed word, only the pc is state
module decode_stage
	import mips_pkg::*;
(
	input  logic         clk,
	input  logic         rst_n,
	input  logic         instr_valid,
	input  instr_t       instr,
	regfile_if.decoder   rf,
	output logic [31:0]  pc,
	output alu_op_t      alu_op,
	output logic [31:0]  operand_b
);

	// raw decode before qualification with instr_valid
	logic        do_write;
	logic        do_jal;
	logic        do_syscall;

	logic [31:0] pc_plus_4;
	logic [31:0] jump_target;

	// immediates in both extension flavours
	logic [31:0] imm_sext;
	logic [31:0] imm_zext;

	assign pc_plus_4 = pc + 32'd4;
	assign imm_sext  = {{16{instr.i_fields.imm16[15]}}, instr.i_fields.imm16};
	assign imm_zext  = {16'd0, instr.i_fields.imm16};

	// pseudo-direct jump, region bits come from the incremented pc
	assign jump_target = {pc_plus_4[31:28], instr.i_fields.rs, instr.i_fields.rt,
	                      instr.i_fields.imm16, 2'b00};

	always_comb begin
		do_write   = 1'b0;
		do_jal     = 1'b0;
		do_syscall = 1'b0;
		alu_op     = ALU_ADD;
		operand_b  = rf.rd2;
		rf.wr_addr = instr.r_fields.rd;
		case (instr.r_fields.opcode)
			OP_RTYPE: begin
				// unknown funct codes fall through as a nop
				case (instr.r_fields.funct)
					F_ADDU:    begin alu_op = ALU_ADD; do_write = 1'b1; end
					F_SUBU:    begin alu_op = ALU_SUB; do_write = 1'b1; end
					F_AND:     begin alu_op = ALU_AND; do_write = 1'b1; end
					F_OR:      begin alu_op = ALU_OR;  do_write = 1'b1; end
					F_SLT:     begin alu_op = ALU_SLT; do_write = 1'b1; end
					F_SYSCALL: do_syscall = 1'b1;
					default:   ;
				endcase
			end
			// I-type results land in rt
			OP_ADDIU: begin
				alu_op     = ALU_ADD;
				operand_b  = imm_sext;
				rf.wr_addr = instr.i_fields.rt;
				do_write   = 1'b1;
			end
			OP_ORI: begin
				alu_op     = ALU_OR;
				operand_b  = imm_zext;
				rf.wr_addr = instr.i_fields.rt;
				do_write   = 1'b1;
			end
			OP_LUI: begin
				alu_op     = ALU_LUI;
				operand_b  = imm_zext;
				rf.wr_addr = instr.i_fields.rt;
				do_write   = 1'b1;
			end
			// the register file swaps in ra and the link value, the ALU just passes it
			OP_JAL: begin
				alu_op   = ALU_PASS_A;
				do_jal   = 1'b1;
				do_write = 1'b1;
			end
			default: ;
		endcase
	end

	assign rf.rs        = instr.r_fields.rs;
	assign rf.rt        = instr.r_fields.rt;
	assign rf.pc_plus_4 = pc_plus_4;

	// nothing reaches the register file unless the word was actually strobed
	assign rf.reg_write = do_write && instr_valid;
	assign rf.jal       = do_jal && instr_valid;
	assign rf.syscall   = do_syscall && instr_valid;

	// pc steps once per accepted instruction
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc <= `RESET_PC;
		end else if (instr_valid) begin
			pc <= do_jal ? jump_target : pc_plus_4;
		end
	end

endmodule

/* mips_core.sv */
`timescale 1ns/1ps

// top level of the core
// one instruction per strobe, write-back and syscall reported one cycle later
module mips_core
	import mips_pkg::*;
(
	input  logic         clk,
	input  logic         rst_n,
	input  logic         instr_valid,
	input  logic [31:0]  instr,
	output logic [31:0]  pc,
	output logic         wb_valid,
	output logic [4:0]   wb_addr,
	output logic [31:0]  wb_data,
	output logic         syscall_valid,
	output logic [31:0]  syscall_code,
	output logic [31:0]  syscall_arg
);

	// decoder to register file bundle
	regfile_if rf_if ();

	// ALU control and second operand chosen by the decoder
	alu_op_t     alu_op;
	logic [31:0] operand_b;
	logic [31:0] alu_result;

	// every result goes back through the register file write port
	assign rf_if.wr_data = alu_result;

	decode_stage decode_stage_inst (
		.clk         (clk),
		.rst_n       (rst_n),
		.instr_valid (instr_valid),
		.instr       (instr),
		.rf          (rf_if.decoder),
		.pc          (pc),
		.alu_op      (alu_op),
		.operand_b   (operand_b)
	);

	register_file register_file_inst (
		.clk           (clk),
		.rst_n         (rst_n),
		.rf            (rf_if.regfile),
		.wb_valid      (wb_valid),
		.wb_addr       (wb_addr),
		.wb_data       (wb_data),
		.syscall_valid (syscall_valid),
		.syscall_code  (syscall_code),
		.syscall_arg   (syscall_arg)
	);

	// operand a comes straight off read port 1, which also carries the jal link value
	alu alu_inst (
		.op     (alu_op),
		.a      (rf_if.rd1),
		.b      (operand_b),
		.result (alu_result)
	);

endmodule

/* mips_core_sva.sv */
`timescale 1ns/1ps
`include "mips_macros.svh"

// protocol checks on the core ports, bound into mips_core
module mips_core_sva (
	input logic        clk,
	input logic        rst_n,
	input logic [31:0] pc,
	input logic        wb_valid,
	input logic [4:0]  wb_addr,
	input logic        syscall_valid
);

	// register zero is never written, so it is never reported either
	property p_no_zero_report;
		@(posedge clk) disable iff (!rst_n)
		wb_valid |-> (wb_addr != `REG_ZERO);
	endproperty

	// a reset edge clears both report strobes
	property p_quiet_after_reset;
		@(posedge clk)
		!rst_n |=> (!wb_valid && !syscall_valid);
	endproperty

	// the pc restarts at the text segment
	property p_reset_pc;
		@(posedge clk)
		!rst_n |=> (pc == `RESET_PC);
	endproperty

	// steps of four and jump targets shifted by two keep it aligned
	property p_pc_aligned;
		@(posedge clk) disable iff (!rst_n)
		pc[1:0] == 2'b00;
	endproperty

	// syscall writes no register, so the two reports never coincide
	property p_reports_exclusive;
		@(posedge clk) disable iff (!rst_n)
		syscall_valid |-> !wb_valid;
	endproperty

	a_no_zero_report: assert property (p_no_zero_report)
		else $error("write-back reported for register zero");

	a_quiet_after_reset: assert property (p_quiet_after_reset)
		else $error("report strobe high right after reset");

	a_reset_pc: assert property (p_reset_pc)
		else $error("pc not at the reset address after reset");

	a_pc_aligned: assert property (p_pc_aligned)
		else $error("pc is not word aligned");

	a_reports_exclusive: assert property (p_reports_exclusive)
		else $error("syscall and write-back reported in the same cycle");

endmodule

/* tb_mips_core.sv */
`timescale 1ns/1ps
`include "mips_macros.svh"

module tb_mips_core
	import mips_pkg::*;
;

	localparam int N_RANDOM    = 500;
	localparam int TEST_CYCLES = 3 + 6 + N_RANDOM + 4;

	logic        clk = 1'b0;
	logic        rst_n;
	logic        instr_valid;
	logic [31:0] instr;
	logic [31:0] pc;
	logic        wb_valid;
	logic [4:0]  wb_addr;
	logic [31:0] wb_data;
	logic        syscall_valid;
	logic [31:0] syscall_code;
	logic [31:0] syscall_arg;

	// shadow architectural state
	logic [31:0] shadow [32];
	logic [31:0] lfsr_state = 32'h350e;

	// expected port values for the coming rising edge, and the ones for the cycle after
	logic [31:0] exp_pc, pend_pc;
	logic        exp_wb_valid, pend_wb_valid;
	logic [4:0]  exp_wb_addr, pend_wb_addr;
	logic [31:0] exp_wb_data, pend_wb_data;
	logic        exp_sc_valid, pend_sc_valid;
	logic [31:0] exp_sc_code, pend_sc_code;
	logic [31:0] exp_sc_arg, pend_sc_arg;

	mips_core mips_core_inst (.*);

	bind mips_core mips_core_sva mips_core_sva_inst (
		.clk           (clk),
		.rst_n         (rst_n),
		.pc            (pc),
		.wb_valid      (wb_valid),
		.wb_addr       (wb_addr),
		.syscall_valid (syscall_valid)
	);

	always #5 clk = ~clk;

	task automatic report_mismatch(input string msg);
		$display("[ERROR] %0d ns: %s", $time, msg);
		$display("Regression failed");
		$fatal(1, "mismatch against the reference model");
	endtask

	// outputs are sampled before the edge, so they show the previous instruction's effect
	a_pc: assert property (@(posedge clk) disable iff (!rst_n) pc == exp_pc)
		else report_mismatch($sformatf("pc %h, expected %h", $sampled(pc), exp_pc));
	a_wb_valid: assert property (@(posedge clk) disable iff (!rst_n) wb_valid == exp_wb_valid)
		else report_mismatch($sformatf("wb_valid %b, expected %b", $sampled(wb_valid),
			exp_wb_valid));
	a_wb_data: assert property (@(posedge clk) disable iff (!rst_n)
		exp_wb_valid |-> (wb_addr == exp_wb_addr && wb_data == exp_wb_data))
		else report_mismatch($sformatf("write-back r%0d=%h, expected r%0d=%h",
			$sampled(wb_addr), $sampled(wb_data), exp_wb_addr, exp_wb_data));
	a_sc_valid: assert property (@(posedge clk) disable iff (!rst_n)
		syscall_valid == exp_sc_valid)
		else report_mismatch($sformatf("syscall_valid %b, expected %b",
			$sampled(syscall_valid), exp_sc_valid));
	a_sc_data: assert property (@(posedge clk) disable iff (!rst_n)
		exp_sc_valid |-> (syscall_code == exp_sc_code && syscall_arg == exp_sc_arg))
		else report_mismatch($sformatf("syscall %h/%h, expected %h/%h",
			$sampled(syscall_code), $sampled(syscall_arg), exp_sc_code, exp_sc_arg));

	// taps 32, 22, 2 and 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		v = 32'd0;
		for (int k = 0; k < n; k++) begin
			lfsr_state = lfsr_step(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
	endtask

	// one pick in eight lands on register zero
	task automatic pick_reg(output logic [4:0] r);
		logic [31:0] v;
		take_bits(3, v);
		if (v[2:0] == 3'd0) begin
			r = `REG_ZERO;
		end else begin
			take_bits(5, v);
			r = v[4:0];
		end
	endtask

	function automatic logic [31:0] model_result(input alu_op_t op, input logic [31:0] a, b);
		case (op)
			ALU_ADD: return a + b;
			ALU_SUB: return a - b;
			ALU_AND: return a & b;
			ALU_OR:  return a | b;
			ALU_SLT: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			ALU_LUI: return {b[15:0], 16'd0};
			default: return a;
		endcase
	endfunction

	// moves last cycle's outcome into the expectation checked at the next edge
	task automatic start_cycle;
		@(negedge clk);
		exp_pc        = pend_pc;
		exp_wb_valid  = pend_wb_valid;
		exp_wb_addr   = pend_wb_addr;
		exp_wb_data   = pend_wb_data;
		exp_sc_valid  = pend_sc_valid;
		exp_sc_code   = pend_sc_code;
		exp_sc_arg    = pend_sc_arg;
		pend_wb_valid = 1'b0;
		pend_sc_valid = 1'b0;
	endtask

	task automatic record_write(input logic [4:0] addr, input logic [31:0] data);
		if (addr != `REG_ZERO) begin
			shadow[addr]  = data;
			pend_wb_valid = 1'b1;
			pend_wb_addr  = addr;
			pend_wb_data  = data;
		end
	endtask

	task automatic exec_rtype(input funct_t f, input alu_op_t op,
		input logic [4:0] rs, rt, rd, sh);
		instr_t w;
		w.r_fields.opcode = OP_RTYPE;
		w.r_fields.rs     = rs;
		w.r_fields.rt     = rt;
		w.r_fields.rd     = rd;
		w.r_fields.shamt  = sh;
		w.r_fields.funct  = f;
		instr_valid = 1'b1;
		instr       = w;
		pend_pc     = exp_pc + 32'd4;
		if (f == F_SYSCALL) begin
			pend_sc_valid = 1'b1;
			pend_sc_code  = shadow[`REG_V0];
			pend_sc_arg   = shadow[`REG_A0];
		end else begin
			record_write(rd, model_result(op, shadow[rs], shadow[rt]));
		end
	endtask

	// addiu sign-extends, ori and lui zero-extend
	task automatic exec_itype(input opcode_t opc, input alu_op_t op,
		input logic [4:0] rs, rt, input logic [15:0] imm);
		instr_t w;
		logic [31:0] b;
		w.i_fields.opcode = opc;
		w.i_fields.rs     = rs;
		w.i_fields.rt     = rt;
		w.i_fields.imm16  = imm;
		b = (opc == OP_ADDIU) ? {{16{imm[15]}}, imm} : {16'd0, imm};
		instr_valid = 1'b1;
		instr       = w;
		pend_pc     = exp_pc + 32'd4;
		record_write(rt, model_result(op, shadow[rs], b));
	endtask

	task automatic exec_jal(input logic [25:0] target);
		instr_t w;
		logic [31:0] link;
		w.i_fields.opcode = OP_JAL;
		{w.i_fields.rs, w.i_fields.rt, w.i_fields.imm16} = target;
		link        = exp_pc + 32'd4;
		instr_valid = 1'b1;
		instr       = w;
		pend_pc     = {link[31:28], target, 2'b00};
		record_write(`REG_RA, link);
	endtask

	// a random word without the strobe must leave everything alone
	task automatic idle_cycle;
		logic [31:0] v;
		take_bits(32, v);
		instr_valid = 1'b0;
		instr       = v;
	endtask

	task automatic random_step;
		logic [31:0] v;
		logic [31:0] kind;
		logic [31:0] sh;
		logic [4:0]  rs, rt, rd;
		take_bits(3, v);
		if (v[2:0] == 3'd0) begin
			idle_cycle();
		end else begin
			take_bits(4, kind);
			pick_reg(rs);
			pick_reg(rt);
			pick_reg(rd);
			take_bits(5, sh);
			take_bits(26, v);
			case (kind[3:0])
				4'd0, 4'd10: exec_rtype(F_ADDU, ALU_ADD, rs, rt, rd, sh[4:0]);
				4'd1, 4'd11: exec_rtype(F_SUBU, ALU_SUB, rs, rt, rd, sh[4:0]);
				4'd2:        exec_rtype(F_AND, ALU_AND, rs, rt, rd, sh[4:0]);
				4'd3:        exec_rtype(F_OR, ALU_OR, rs, rt, rd, sh[4:0]);
				4'd4, 4'd12: exec_rtype(F_SLT, ALU_SLT, rs, rt, rd, sh[4:0]);
				4'd5, 4'd13: exec_itype(OP_ADDIU, ALU_ADD, rs, rt, v[15:0]);
				4'd6, 4'd14: exec_itype(OP_ORI, ALU_OR, rs, rt, v[15:0]);
				4'd7:        exec_itype(OP_LUI, ALU_LUI, rs, rt, v[15:0]);
				4'd8:        exec_jal(v[25:0]);
				default:     exec_rtype(F_SYSCALL, ALU_ADD, 5'd0, 5'd0, 5'd0, 5'd0);
			endcase
		end
	endtask

	initial begin
		rst_n       = 1'b0;
		instr_valid = 1'b0;
		instr       = 32'd0;
		for (int k = 0; k < 32; k++) begin
			shadow[k] = 32'd0;
		end
		shadow[`REG_SP] = `STACK_TOP - 32'd4;
		pend_pc         = `RESET_PC;
		pend_wb_valid   = 1'b0;
		pend_sc_valid   = 1'b0;
		repeat (3) @(posedge clk);
		start_cycle();
		rst_n = 1'b1;
		// first instruction reads the preset sp
		exec_rtype(F_ADDU, ALU_ADD, `REG_SP, `REG_ZERO, 5'd8, 5'd0);
		start_cycle();
		exec_itype(OP_ADDIU, ALU_ADD, `REG_ZERO, `REG_V0, 16'h000a);
		start_cycle();
		exec_itype(OP_ADDIU, ALU_ADD, `REG_ZERO, `REG_A0, 16'hfff0);
		start_cycle();
		exec_rtype(F_SYSCALL, ALU_ADD, 5'd0, 5'd0, 5'd0, 5'd0);
		start_cycle();
		exec_jal(26'h012_3456);
		start_cycle();
		exec_itype(OP_LUI, ALU_LUI, `REG_ZERO, `REG_ZERO, 16'hbeef);
		for (int n = 0; n < N_RANDOM; n++) begin
			start_cycle();
			random_step();
		end
		// drain the last report through the checks
		start_cycle();
		idle_cycle();
		start_cycle();
		idle_cycle();
		@(negedge clk);
		$display("Regression passed");
		$finish;
	end

	initial begin
		#(TEST_CYCLES * 10 * 2);
		$display("timeout: the run did not finish within %0d cycles", TEST_CYCLES * 2);
		$display("Regression failed");
		$fatal(1, "watchdog expired");
	end

endmodule

/* files.f */
+incdir+.
mips_pkg.sv
regfile_if.sv
alu.sv
register_file.sv
decode_stage.sv
mips_core.sv
mips_core_sva.sv
tb_mips_core.sv

/* Makefile */
# Verilator build for the MIPS core testbench

VERILATOR ?= verilator
TOP       ?= tb_mips_core
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)

SRCS := $(filter %.sv %.v,$(shell cat $(FILELIST)))
HDRS := $(wildcard *.svh)
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

# rebuilt only when a source, a header or the file list changes
$(SIM): $(FILELIST) $(SRCS) $(HDRS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the exit status of the simulator is the result of the run
run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)
